//--- all.f
+incdir+verilog
verilog/corr_pkg.sv
verilog/vis_correlator.sv
verilog/vis_fifo.sv
verilog/vis_readout.sv
verilog/corr_top.sv
verif/tb_corr_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_corr_top -f all.f -o Vtb_corr_top

./obj_dir/Vtb_corr_top | tee sim.log

if grep -qx "Regression passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

//--- verif/tb_corr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_defs.svh"

module tb_corr_top;

  import corr_pkg::*;

  logic      CLK_16, arst_n_i, sig_valid_i, rd_stb_i;
  ant_bits_t sig_i_i, sig_q_i;
  byte_t     byte_o;
  logic      byte_valid_o, busy_o, overflow_o, underrun_o;
  fifo_cnt_t fill_o;

  ant_bits_t win_i [`CORR_VIS_SAMPLES];  // Valid samples of the open window
  ant_bits_t win_q [`CORR_VIS_SAMPLES];
  vis_rec_t  pend_q [$];    // Records still on their way to the FIFO
  int        pend_due [$];
  vis_rec_t  exp_q [$];     // FIFO mirror
  byte_t     exp_bytes [$];
  vis_rec_t  cur;
  frame_t    frame;
  logic      exp_ovf, exp_unr, exp_bv;
  int        cyc, vcnt, rd_pos, overlap;
  int        errors = 0;
  int        checks = 0;

  corr_top u_dut (.*);

  initial begin
    CLK_16 = 1'b0;
    forever #50 CLK_16 = ~CLK_16;
  end

  // +1 when the bits agree, -1 otherwise
  function automatic int bit_prod(input logic a, input logic b);
    return (a == b) ? 1 : -1;
  endfunction

  function automatic vis_rec_t ref_vis(input ant_bits_t wi [`CORR_VIS_SAMPLES],
                                       input ant_bits_t wq [`CORR_VIS_SAMPLES],
                                       input int pair, input frame_t fr);
    int idx, a, b, re, im;
    vis_rec_t r;
    idx = 0;
    a = 0;
    b = 0;
    re = 0;
    im = 0;
    for (int x = 0; x < `CORR_ANTENNAS; x++)  // Pair order (0,1) (0,2) ... (2,3)
      for (int y = x + 1; y < `CORR_ANTENNAS; y++) begin
        if (idx == pair) begin
          a = x;
          b = y;
        end
        idx++;
      end
    for (int s = 0; s < `CORR_VIS_SAMPLES; s++) begin
      re += bit_prod(wi[s][a], wi[s][b]) + bit_prod(wq[s][a], wq[s][b]);
      im += bit_prod(wq[s][a], wi[s][b]) - bit_prod(wi[s][a], wq[s][b]);
    end
    r.frame = fr;
    r.pair  = pair_idx_t'(pair);
    r.re    = vis_t'(re);
    r.im    = vis_t'(im);
    return r;
  endfunction

  function automatic byte_t record_byte(input vis_rec_t r, input int pos);
    case (pos)
      0: return r.frame;
      1: return byte_t'(r.pair);
      2: return r.re[15:8];
      3: return r.re[7:0];
      4: return r.im[15:8];
      default: return r.im[7:0];
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic abort(input string why);
    $display("Timeout: %s", why);
    $display("Regression failed");
    $finish;
  endtask

  // FIFO and readout mirror on the DUT clock edges
  always @(posedge CLK_16) begin : model
    logic popped;
    if (!arst_n_i) begin
      exp_q.delete();
      pend_q.delete();
      pend_due.delete();
      exp_bytes.delete();
      {exp_ovf, exp_unr, exp_bv} = 3'b000;
      frame = '0;
      cyc = 0;
      vcnt = 0;
      rd_pos = 0;
      overlap = 0;
    end else begin
      cyc++;
      check("fill_o", fill_o, exp_q.size());
      check("busy_o", busy_o, rd_pos != 0);
      check("overflow_o", overflow_o, exp_ovf);
      check("underrun_o", underrun_o, exp_unr);
      check("byte_valid_o", byte_valid_o, exp_bv);
      popped = 1'b0;
      exp_bv = 1'b0;
      if (rd_stb_i && rd_pos == 0 && exp_q.size() == 0) exp_unr = 1'b1;
      else if (rd_stb_i) begin
        exp_bv = 1'b1;  // Byte due one cycle later
        if (rd_pos == 0) begin
          cur = exp_q.pop_front();
          popped = 1'b1;
        end
        exp_bytes.push_back(record_byte(cur, rd_pos));
        rd_pos = (rd_pos == `CORR_REC_BYTES - 1) ? 0 : rd_pos + 1;
      end
      while (pend_due.size() != 0 && pend_due[0] == cyc) begin
        if (exp_q.size() < `CORR_FIFO_DEPTH) exp_q.push_back(pend_q[0]);
        else exp_ovf = 1'b1;  // Dropped
        if (popped) overlap++;
        void'(pend_due.pop_front());
        void'(pend_q.pop_front());
      end
      if (sig_valid_i) begin
        win_i[vcnt] = sig_i_i;
        win_q[vcnt] = sig_q_i;
        vcnt++;
        if (vcnt == `CORR_VIS_SAMPLES) begin
          for (int p = 0; p < `CORR_PAIRS; p++) begin
            pend_q.push_back(ref_vis(win_i, win_q, p, frame));
            pend_due.push_back(cyc + 3 + p);  // First FIFO write 3 cycles after capture
          end
          frame++;
          vcnt = 0;
        end
      end
    end
  end

  always @(posedge CLK_16) begin
    if (arst_n_i && byte_valid_o) begin
      if (exp_bytes.size() == 0) begin
        errors++;
        $display("DUT returned byte 0x%0h when no byte was expected", byte_o);
      end else check("byte_o", byte_o, exp_bytes.pop_front());
    end
  end

  task automatic apply_reset();
    @(posedge CLK_16);
    arst_n_i <= 1'b0;
    sig_valid_i <= 1'b0;
    rd_stb_i <= 1'b0;
    repeat (3) @(posedge CLK_16);
    arst_n_i <= 1'b1;
  endtask

  task automatic run_windows(input int n, input int pct);
    int cnt, guard;
    logic v;
    cnt = 0;
    guard = 0;
    while (cnt < n * `CORR_VIS_SAMPLES) begin
      @(posedge CLK_16);
      v = ($urandom % 100) < pct;
      sig_valid_i <= v;
      sig_i_i <= ant_bits_t'($urandom);
      sig_q_i <= ant_bits_t'($urandom);
      cnt += v;
      guard++;
      if (guard > 100 * n * `CORR_VIS_SAMPLES) abort("stimulus never completed its windows");
    end
    @(posedge CLK_16) sig_valid_i <= 1'b0;
  endtask

  // Host reads one whole record once the FIFO holds one
  task automatic read_record();
    int guard;
    guard = 0;
    while (fill_o == 0) begin
      @(posedge CLK_16);
      guard++;
      if (guard > 500) abort("no record arrived for the host read");
    end
    repeat (`CORR_REC_BYTES) @(posedge CLK_16) rd_stb_i <= 1'b1;
    @(posedge CLK_16) rd_stb_i <= 1'b0;
  endtask

  task automatic drain_fifo();
    int n;
    n = 0;
    repeat (10) @(posedge CLK_16);  // Last record lands 9 cycles after its sample
    while (fill_o != 0) begin
      read_record();
      n++;
      if (n > 2 * `CORR_FIFO_DEPTH) abort("FIFO never drained");
    end
    repeat (2) @(posedge CLK_16);
    @(negedge CLK_16);
    check("exp_bytes.size", exp_bytes.size(), 0);
  endtask

  initial begin
    int err0;
    void'($urandom(10));
    arst_n_i = 1'b0;
    sig_valid_i = 1'b0;
    rd_stb_i = 1'b0;
    sig_i_i = '0;
    sig_q_i = '0;
    apply_reset();

    err0 = errors;
    @(negedge CLK_16);
    check("byte_valid_o", byte_valid_o, 0);
    check("busy_o", busy_o, 0);
    check("overflow_o", overflow_o, 0);
    check("underrun_o", underrun_o, 0);
    check("fill_o", fill_o, 0);
    @(posedge CLK_16) rd_stb_i <= 1'b1;
    @(posedge CLK_16) rd_stb_i <= 1'b0;
    repeat (2) @(posedge CLK_16);
    @(negedge CLK_16);
    check("underrun_o", underrun_o, 1);
    $display("Test 1 reset state and empty read: %0d errors", errors - err0);

    err0 = errors;
    run_windows(3, 100);
    drain_fifo();
    $display("Test 2 windows with valid always high: %0d errors", errors - err0);

    err0 = errors;
    run_windows(3, 60);
    drain_fifo();
    $display("Test 3 windows with gaps in valid: %0d errors", errors - err0);

    err0 = errors;
    repeat (256) begin  // Short bursts until the frame byte wraps
      run_windows(1, 100);
      drain_fifo();
    end
    $display("Test 4 frame count through wrap: %0d errors", errors - err0);

    err0 = errors;
    run_windows(3, 100);
    repeat (10) @(posedge CLK_16);
    @(negedge CLK_16);
    check("fill_o", fill_o, `CORR_FIFO_DEPTH);
    check("overflow_o", overflow_o, 1);
    drain_fifo();
    $display("Test 5 overflow with no reads: %0d errors", errors - err0);

    err0 = errors;
    apply_reset();
    fork
      run_windows(4, 100);
      repeat (4 * `CORR_PAIRS) read_record();
    join
    drain_fifo();
    check("overflow_o", overflow_o, 0);
    check("push_pop_overlap", overlap != 0, 1);
    $display("Test 6 reads in step with production: %0d errors", errors - err0);

    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("Regression passed");
    else $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// Array geometry
`define CORR_ANTENNAS 4
`define CORR_PAIRS 6       // 4 choose 2

// Integration window, counted in valid samples only
`define CORR_VIS_SAMPLES 32

// Width of one visibility component, signed
`define CORR_VIS_BITS 16

// Record buffer depth, must be a power of two
`define CORR_FIFO_DEPTH 16

// Host readout: frame, pair, re hi/lo, im hi/lo
`define CORR_REC_BYTES 6

`endif

//--- verilog/corr_pkg.sv
`default_nettype none

`include "corr_defs.svh"

package corr_pkg;

  // One sample bit per antenna
  typedef logic [`CORR_ANTENNAS-1:0] ant_bits_t;

  typedef logic signed [`CORR_VIS_BITS-1:0] vis_t;  // Visibility component

  typedef logic [2:0] pair_idx_t;  // Pair 0 to 5

  typedef logic [7:0] frame_t;  // Window count, wraps
  typedef logic [7:0] byte_t;

  // Needs to hold DEPTH itself, hence the +1
  typedef logic [$clog2(`CORR_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // One visibility record, frame in the top bits
  typedef struct packed {
    frame_t    frame;
    pair_idx_t pair;
    vis_t      re;
    vis_t      im;
  } vis_rec_t;

endpackage

`default_nettype wire

//--- verilog/corr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_defs.svh"

module corr_top (
  input  wire                 CLK_16,
  input  wire                 arst_n_i,
  input  wire                 sig_valid_i,
  input  corr_pkg::ant_bits_t sig_i_i,
  input  corr_pkg::ant_bits_t sig_q_i,
  input  wire                 rd_stb_i,
  output corr_pkg::byte_t     byte_o,
  output logic                byte_valid_o,
  output logic                busy_o,
  output logic                overflow_o,
  output logic                underrun_o,
  output corr_pkg::fifo_cnt_t fill_o
);

  import corr_pkg::*;

  logic     rec_valid;
  vis_rec_t rec;
  vis_rec_t head;
  logic     empty;
  logic     pop;

  vis_correlator u_correlator (
    .CLK_16      (CLK_16),
    .arst_n_i    (arst_n_i),
    .sig_valid_i (sig_valid_i),
    .sig_i_i     (sig_i_i),
    .sig_q_i     (sig_q_i),
    .rec_valid_o (rec_valid),
    .rec_o       (rec)
  );

  // Record buffer, no back-pressure towards the correlator
  vis_fifo #(
    .DEPTH (`CORR_FIFO_DEPTH)
  ) u_fifo (
    .CLK_16     (CLK_16),
    .arst_n_i   (arst_n_i),
    .push_i     (rec_valid),
    .pop_i      (pop),
    .rec_i      (rec),
    .head_o     (head),
    .empty_o    (empty),
    .overflow_o (overflow_o),
    .fill_o     (fill_o)
  );

  vis_readout u_readout (
    .CLK_16       (CLK_16),
    .arst_n_i     (arst_n_i),
    .rd_stb_i     (rd_stb_i),
    .empty_i      (empty),
    .head_i       (head),
    .pop_o        (pop),
    .byte_o       (byte_o),
    .byte_valid_o (byte_valid_o),
    .busy_o       (busy_o),
    .underrun_o   (underrun_o)
  );

endmodule

`default_nettype wire

//--- verilog/vis_correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_defs.svh"

module vis_correlator (
  input  wire                  CLK_16,
  input  wire                  arst_n_i,
  input  wire                  sig_valid_i,
  input  corr_pkg::ant_bits_t  sig_i_i,
  input  corr_pkg::ant_bits_t  sig_q_i,
  output logic                 rec_valid_o,
  output corr_pkg::vis_rec_t   rec_o
);

  import corr_pkg::*;

  localparam int CNT_W = $clog2(`CORR_VIS_SAMPLES);
  localparam pair_idx_t LAST_PAIR = pair_idx_t'(`CORR_PAIRS - 1);

  // Antenna a and b of each pair, in fixed pair order
  localparam int PAIR_A [`CORR_PAIRS] = '{0, 0, 0, 1, 1, 2};
  localparam int PAIR_B [`CORR_PAIRS] = '{1, 2, 3, 2, 3, 3};

  // +1 when the two bits agree, -1 otherwise
  function automatic vis_t pm(input logic a, input logic b);
    return (a == b) ? vis_t'(1) : -vis_t'(1);
  endfunction

  ant_bits_t samp_i_q;
  ant_bits_t samp_q_q;
  logic      samp_v_q;

  logic [CNT_W-1:0] samp_cnt;
  logic             win_end;
  frame_t           frame_cnt;

  vis_t re_d [`CORR_PAIRS];
  vis_t im_d [`CORR_PAIRS];
  vis_t acc_re [`CORR_PAIRS];
  vis_t acc_im [`CORR_PAIRS];
  vis_t shad_re [`CORR_PAIRS];
  vis_t shad_im [`CORR_PAIRS];
  frame_t shad_frame;

  logic      draining;
  pair_idx_t ptr;

  // Input capture
  always_ff @(posedge CLK_16 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      samp_v_q <= 1'b0;
    end else begin
      samp_v_q <= sig_valid_i;
    end
  end

  always_ff @(posedge CLK_16) begin
    samp_i_q <= sig_i_i;
    samp_q_q <= sig_q_i;
  end

  // Per-sample contribution of every pair
  always_comb begin
    for (int p = 0; p < `CORR_PAIRS; p++) begin
      re_d[p] = pm(samp_i_q[PAIR_A[p]], samp_i_q[PAIR_B[p]])
              + pm(samp_q_q[PAIR_A[p]], samp_q_q[PAIR_B[p]]);
      im_d[p] = pm(samp_q_q[PAIR_A[p]], samp_i_q[PAIR_B[p]])
              - pm(samp_i_q[PAIR_A[p]], samp_q_q[PAIR_B[p]]);
    end
  end

  assign win_end = samp_v_q && (samp_cnt == CNT_W'(`CORR_VIS_SAMPLES - 1));

  always_ff @(posedge CLK_16 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      samp_cnt  <= '0;
      frame_cnt <= '0;
      for (int p = 0; p < `CORR_PAIRS; p++) begin
        acc_re[p] <= '0;
        acc_im[p] <= '0;
      end
    end else if (samp_v_q) begin
      samp_cnt <= samp_cnt + 1'b1;  // Wraps at window end
      if (win_end) begin
        frame_cnt <= frame_cnt + 1'b1;
        for (int p = 0; p < `CORR_PAIRS; p++) begin
          acc_re[p] <= '0;  // Next window starts clean
          acc_im[p] <= '0;
        end
      end else begin
        for (int p = 0; p < `CORR_PAIRS; p++) begin
          acc_re[p] <= acc_re[p] + re_d[p];
          acc_im[p] <= acc_im[p] + im_d[p];
        end
      end
    end
  end

  // Shadow bank, last sample folded in on the way
  always_ff @(posedge CLK_16) begin
    if (win_end) begin
      shad_frame <= frame_cnt;
      for (int p = 0; p < `CORR_PAIRS; p++) begin
        shad_re[p] <= acc_re[p] + re_d[p];
        shad_im[p] <= acc_im[p] + im_d[p];
      end
    end
  end

  // Drain one pair per cycle while the next window integrates
  always_ff @(posedge CLK_16 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      draining    <= 1'b0;
      ptr         <= '0;
      rec_valid_o <= 1'b0;
    end else begin
      rec_valid_o <= draining;
      if (win_end) begin
        draining <= 1'b1;
        ptr      <= '0;
      end else if (draining) begin
        ptr      <= (ptr == LAST_PAIR) ? '0 : ptr + 1'b1;
        draining <= (ptr != LAST_PAIR);
      end
    end
  end

  always_ff @(posedge CLK_16) begin
    if (draining) begin
      rec_o <= '{frame: shad_frame, pair: ptr, re: shad_re[ptr], im: shad_im[ptr]};
    end
  end

  // Drain pointer stays inside the shadow bank
  a_ptr_range: assert property (@(posedge CLK_16) disable iff (!arst_n_i)
    ptr <= LAST_PAIR);

endmodule

`default_nettype wire

//--- verilog/vis_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_defs.svh"

module vis_fifo #(
  parameter int DEPTH = `CORR_FIFO_DEPTH
) (
  input  wire                 CLK_16,
  input  wire                 arst_n_i,
  input  wire                 push_i,
  input  wire                 pop_i,
  input  corr_pkg::vis_rec_t  rec_i,
  output corr_pkg::vis_rec_t  head_o,
  output logic                empty_o,
  output logic                overflow_o,
  output corr_pkg::fifo_cnt_t fill_o
);

  import corr_pkg::*;

  localparam int AW = $clog2(DEPTH);

  vis_rec_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign empty_o = (fill_o == '0);
  assign full    = (fill_o == fifo_cnt_t'(DEPTH));
  assign head_o  = mem[rd_ptr];  // Show-ahead

  // A pop frees the slot for a push in the same cycle
  assign rd_en = pop_i && !empty_o;
  assign wr_en = push_i && (!full || rd_en);

  always_ff @(posedge CLK_16) begin
    if (wr_en) mem[wr_ptr] <= rec_i;
  end

  always_ff @(posedge CLK_16 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_o     <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Power-of-two wrap
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) fill_o <= fill_o + 1'b1;
      else if (rd_en && !wr_en) fill_o <= fill_o - 1'b1;
      if (push_i && !wr_en) overflow_o <= 1'b1;  // Sticky until reset
    end
  end

  // Readout must check empty before popping
  a_no_pop_empty: assert property (@(posedge CLK_16) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

  a_fill_bound: assert property (@(posedge CLK_16) disable iff (!arst_n_i)
    fill_o <= fifo_cnt_t'(DEPTH));

endmodule

`default_nettype wire

//--- verilog/vis_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_defs.svh"

module vis_readout (
  input  wire                 CLK_16,
  input  wire                 arst_n_i,
  input  wire                 rd_stb_i,
  input  wire                 empty_i,
  input  corr_pkg::vis_rec_t  head_i,
  output logic                pop_o,
  output corr_pkg::byte_t     byte_o,
  output logic                byte_valid_o,
  output logic                busy_o,
  output logic                underrun_o
);

  import corr_pkg::*;

  localparam logic [2:0] LAST_POS = 3'(`CORR_REC_BYTES - 1);

  logic [2:0] pos;
  vis_rec_t   rec_q;
  vis_rec_t   src;
  logic       served;
  byte_t      byte_d;

  // Byte 0 comes straight from the FIFO head, the rest from the held copy
  assign src = (pos == '0) ? head_i : rec_q;

  always_comb begin
    case (pos)
      3'd0:    byte_d = src.frame;
      3'd1:    byte_d = byte_t'(src.pair);  // Zero-extended
      3'd2:    byte_d = src.re[15:8];
      3'd3:    byte_d = src.re[7:0];
      3'd4:    byte_d = src.im[15:8];
      default: byte_d = src.im[7:0];
    endcase
  end

  assign served = rd_stb_i && ((pos != '0) || !empty_i);
  assign pop_o  = rd_stb_i && (pos == '0) && !empty_i;
  assign busy_o = (pos != '0);

  always_ff @(posedge CLK_16 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pos          <= '0;
      byte_valid_o <= 1'b0;
      underrun_o   <= 1'b0;
    end else begin
      byte_valid_o <= served;
      if (served) begin
        pos <= (pos == LAST_POS) ? '0 : pos + 1'b1;
      end
      if (rd_stb_i && !served) underrun_o <= 1'b1;
    end
  end

  always_ff @(posedge CLK_16) begin
    if (served) byte_o <= byte_d;
    if (pop_o) rec_q <= head_i;  // Held for bytes 1 to 5
  end

  // Every byte answers a strobe one cycle earlier
  a_byte_after_stb: assert property (@(posedge CLK_16) disable iff (!arst_n_i)
    byte_valid_o |-> $past(rd_stb_i));

endmodule

`default_nettype wire
